//--- pkt_tag_settings.svh
// Bank address width and sequence field width for the packet tagger
`ifndef PKT_TAG_SETTINGS_SVH
`define PKT_TAG_SETTINGS_SVH

// Address bits per bank
// 9 bits give 512 lines, which is also the longest packet
`define PKT_TAG_AW 9

// Width of the sequence number written into line 0
`define PKT_TAG_SEQ_W 16

`endif

//--- pkt_tag_pkg.sv
// Line, address, length and sequence types, flag bit positions and bank states
`default_nettype none

`include "pkt_tag_settings.svh"

package pkt_tag_pkg;

   // Flag bits in the upper nibble of a line, bit 35 is spare
   localparam int SOF_BIT  = 32;
   localparam int EOF_BIT  = 33;
   localparam int DROP_BIT = 34;

   // Length occupies the low field of line 0, sequence sits right above it
   localparam int LEN_W = 16;

   typedef logic [35:0] line_t;
   typedef logic [`PKT_TAG_AW-1:0] adr_t;
   // One extra bit so a completely full bank can be counted
   typedef logic [`PKT_TAG_AW:0] len_t;
   typedef logic [`PKT_TAG_SEQ_W-1:0] seq_t;

   typedef enum logic [1:0] {
      BANK_EMPTY,
      BANK_FILLING,
      BANK_ACCESS,
      BANK_READING
   } bank_state_t;

endpackage

`default_nettype wire

//--- ram_2port.sv
// True dual-port line RAM with registered read data on both ports
`timescale 1ns/1ps
`default_nettype none

`include "pkt_tag_settings.svh"

module ram_2port
   import pkt_tag_pkg::*;
(
   input  logic  clk,
   input  logic  ena_i,
   input  logic  wea_i,
   input  adr_t  addra_i,
   input  line_t dia_i,
   output line_t doa_o,
   input  logic  enb_i,
   input  logic  web_i,
   input  adr_t  addrb_i,
   input  line_t dib_i,
   output line_t dob_o
);

   localparam int DEPTH = 1 << `PKT_TAG_AW;

   line_t mem [DEPTH];

   // Port A, read-first
   always @(posedge clk)
   begin
      if (ena_i)
      begin
         if (wea_i)
         begin
            mem[addra_i] <= dia_i;
         end
         doa_o <= mem[addra_i];
      end
   end

   // Port B, read-first
   always @(posedge clk)
   begin
      if (enb_i)
      begin
         if (web_i)
         begin
            mem[addrb_i] <= dib_i;
         end
         dob_o <= mem[addrb_i];
      end
   end

endmodule

`default_nettype wire

//--- dbsm.sv
// Bank state tracking for the two-bank buffer: write, access and read pointers
`timescale 1ns/1ps
`default_nettype none

`include "pkt_tag_settings.svh"

module dbsm
   import pkt_tag_pkg::*;
(
   input  logic clk,
   input  logic rst_n_i,
   output logic write_ok_o,
   output logic write_ptr_o,
   input  logic write_done_i,
   output logic access_ok_o,
   output logic access_ptr_o,
   input  logic access_done_i,
   input  logic access_skip_read_i,
   output logic read_ok_o,
   output logic read_ptr_o,
   input  logic read_done_i
);

   bank_state_t state_q [2];
   logic        write_ptr_q;
   logic        access_ptr_q;
   logic        read_ptr_q;
   logic        skip_pend_q;
   logic        skip;
   logic        skip_now;
   logic        skip_late;

   // A skipped bank must also be stepped over by the read pointer.
   // If reading still sits on the older bank, the step waits for its read_done
   assign skip      = access_done_i & access_skip_read_i;
   assign skip_now  = skip & (access_ptr_q == read_ptr_q);
   assign skip_late = skip & (access_ptr_q != read_ptr_q);

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         state_q[0]   <= BANK_EMPTY;
         state_q[1]   <= BANK_EMPTY;
         write_ptr_q  <= 1'b0;
         access_ptr_q <= 1'b0;
         read_ptr_q   <= 1'b0;
         skip_pend_q  <= 1'b0;
      end
      else
      begin
         for (int i = 0; i < 2; i++)
         begin
            // Write side claims an empty bank, EOF hands it to access
            if (write_done_i && (write_ptr_q == 1'(i)))
            begin
               state_q[i] <= BANK_ACCESS;
            end
            else if ((state_q[i] == BANK_EMPTY) && (write_ptr_q == 1'(i)))
            begin
               state_q[i] <= BANK_FILLING;
            end
            if (access_done_i && (access_ptr_q == 1'(i)))
            begin
               state_q[i] <= access_skip_read_i ? BANK_EMPTY : BANK_READING;
            end
            if (read_done_i && (read_ptr_q == 1'(i)))
            begin
               state_q[i] <= BANK_EMPTY;
            end
         end

         if (write_done_i)
         begin
            write_ptr_q <= ~write_ptr_q;
         end
         if (access_done_i)
         begin
            access_ptr_q <= ~access_ptr_q;
         end

         // Late skip plus read_done means two steps, which cancel out
         if (skip_now ^ (read_done_i & ~skip_pend_q & ~skip_late))
         begin
            read_ptr_q <= ~read_ptr_q;
         end
         if (read_done_i)
         begin
            skip_pend_q <= 1'b0;
         end
         else if (skip_late)
         begin
            skip_pend_q <= 1'b1;
         end
      end
   end

   assign write_ok_o   = (state_q[write_ptr_q] == BANK_EMPTY) ||
                         (state_q[write_ptr_q] == BANK_FILLING);
   assign access_ok_o  = (state_q[access_ptr_q] == BANK_ACCESS);
   assign read_ok_o    = (state_q[read_ptr_q] == BANK_READING);
   assign write_ptr_o  = write_ptr_q;
   assign access_ptr_o = access_ptr_q;
   assign read_ptr_o   = read_ptr_q;

endmodule

`default_nettype wire

//--- double_buffer.sv
// Two-bank packet buffer with stream write, random access and stream read sides
`timescale 1ns/1ps
`default_nettype none

`include "pkt_tag_settings.svh"

module double_buffer
   import pkt_tag_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n_i,
   input  logic  access_we_i,
   input  logic  access_stb_i,
   output logic  access_ok_o,
   input  logic  access_done_i,
   input  logic  access_skip_read_i,
   input  adr_t  access_adr_i,
   output len_t  access_len_o,
   input  line_t access_dat_i,
   output line_t access_dat_o,
   input  line_t data_i,
   input  logic  src_rdy_i,
   output logic  dst_rdy_o,
   output line_t data_o,
   output logic  src_rdy_o,
   input  logic  dst_rdy_i
);

   typedef enum logic [1:0] {IDLE, PRE_READ, READING} read_state_t;

   logic        write_ok;
   logic        write_ptr;
   logic        write_done;
   logic        write_en;
   logic        access_ptr;
   logic        read_ok;
   logic        read_ptr;
   logic        read_done;
   logic        read_en;
   adr_t        write_adr;
   adr_t        read_adr;
   len_t        len_q [2];
   line_t       bank_doa [2];
   line_t       bank_dob [2];
   read_state_t read_state;

   dbsm u_dbsm (
      .clk                (clk),
      .rst_n_i            (rst_n_i),
      .write_ok_o         (write_ok),
      .write_ptr_o        (write_ptr),
      .write_done_i       (write_done),
      .access_ok_o        (access_ok_o),
      .access_ptr_o       (access_ptr),
      .access_done_i      (access_done_i),
      .access_skip_read_i (access_skip_read_i),
      .read_ok_o          (read_ok),
      .read_ptr_o         (read_ptr),
      .read_done_i        (read_done)
   );

   // Port A serves the header engine, port B the write counter or the reader
   for (genvar i = 0; i < 2; i++)
   begin : g_bank
      ram_2port u_ram (
         .clk     (clk),
         .ena_i   (access_stb_i & access_ok_o & (access_ptr == 1'(i))),
         .wea_i   (access_we_i),
         .addra_i (access_adr_i),
         .dia_i   (access_dat_i),
         .doa_o   (bank_doa[i]),
         .enb_i   ((read_en & read_ok & (read_ptr == 1'(i))) |
                   (write_en & (write_ptr == 1'(i)))),
         .web_i   (write_en & (write_ptr == 1'(i))),
         .addrb_i ((read_ok & (read_ptr == 1'(i))) ? read_adr : write_adr),
         .dib_i   (data_i),
         .dob_o   (bank_dob[i])
      );
   end

   assign access_dat_o = bank_doa[access_ptr];
   assign access_len_o = len_q[access_ptr];
   assign data_o       = bank_dob[read_ptr];

   // Write side
   assign dst_rdy_o  = write_ok;
   assign write_en   = src_rdy_i & write_ok;
   assign write_done = write_en & data_i[EOF_BIT];

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         write_adr <= '0;
      end
      else if (write_done)
      begin
         write_adr <= '0;
      end
      else if (write_en)
      begin
         write_adr <= write_adr + adr_t'(1);
      end
   end

   // Length of each bank, captured on its EOF line
   always_ff @(posedge clk)
   begin
      if (write_done)
      begin
         len_q[write_ptr] <= len_t'(write_adr) + len_t'(1);
      end
   end

   // Read side, address runs one line ahead of data_o
   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         read_state <= IDLE;
         read_adr   <= '0;
      end
      else
      begin
         case (read_state)
            IDLE:
            begin
               read_adr <= '0;
               if (read_ok)
               begin
                  read_state <= PRE_READ;
               end
            end
            PRE_READ:
            begin
               read_adr   <= adr_t'(1);
               read_state <= READING;
            end
            READING:
            begin
               if (dst_rdy_i)
               begin
                  read_adr <= read_adr + adr_t'(1);
                  if (data_o[EOF_BIT])
                  begin
                     read_state <= IDLE;
                  end
               end
            end
            default:
            begin
               read_state <= IDLE;
            end
         endcase
      end
   end

   // Stalled sink freezes the RAM output register
   assign read_en   = ~((read_state == READING) & ~dst_rdy_i);
   assign src_rdy_o = (read_state == READING);
   assign read_done = data_o[EOF_BIT] & dst_rdy_i & src_rdy_o;

endmodule

`default_nettype wire

//--- hdr_tagger.sv
// Header engine that drops a packet or writes length and sequence into line 0
`timescale 1ns/1ps
`default_nettype none

`include "pkt_tag_settings.svh"

module hdr_tagger
   import pkt_tag_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n_i,
   input  logic  access_ok_i,
   input  len_t  access_len_i,
   input  line_t access_dat_i,
   output logic  access_stb_o,
   output logic  access_we_o,
   output adr_t  access_adr_o,
   output line_t access_dat_o,
   output logic  access_done_o,
   output logic  access_skip_read_o
);

   typedef enum logic [1:0] {WAIT, FETCH, UPDATE} tag_state_t;

   tag_state_t state_q;
   tag_state_t state_d;
   seq_t       seq_q;

   // Only line 0 is ever touched
   assign access_adr_o = '0;

   // Flags stay, length and sequence fields are replaced
   always_comb
   begin
      access_dat_o = access_dat_i;
      access_dat_o[LEN_W-1:0] = LEN_W'(access_len_i);
      access_dat_o[LEN_W +: `PKT_TAG_SEQ_W] = seq_q;
   end

   always_comb
   begin
      state_d            = state_q;
      access_stb_o       = 1'b0;
      access_we_o        = 1'b0;
      access_done_o      = 1'b0;
      access_skip_read_o = 1'b0;
      case (state_q)
         // UPDATE can already start the next bank
         WAIT, UPDATE:
         begin
            state_d = WAIT;
            if (access_ok_i)
            begin
               access_stb_o = 1'b1;
               state_d      = FETCH;
            end
         end
         FETCH:
         begin
            access_done_o = 1'b1;
            if (access_dat_i[DROP_BIT])
            begin
               access_skip_read_o = 1'b1;
               state_d            = WAIT;
            end
            else
            begin
               access_stb_o = 1'b1;
               access_we_o  = 1'b1;
               state_d      = UPDATE;
            end
         end
         default:
         begin
            state_d = WAIT;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         state_q <= WAIT;
         seq_q   <= '0;
      end
      else
      begin
         state_q <= state_d;
         // Dropped packets never reach UPDATE, so they use no number
         if (state_q == UPDATE)
         begin
            seq_q <= seq_q + seq_t'(1);
         end
      end
   end

endmodule

`default_nettype wire

//--- pkt_tag_top.sv
// Packet header tagger top level with the buffer and the header engine
`timescale 1ns/1ps
`default_nettype none

`include "pkt_tag_settings.svh"

module pkt_tag_top
   import pkt_tag_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n_i,
   input  line_t in_data_i,
   input  logic  in_src_rdy_i,
   output logic  in_dst_rdy_o,
   output line_t out_data_o,
   output logic  out_src_rdy_o,
   input  logic  out_dst_rdy_i
);

   logic  access_ok;
   logic  access_stb;
   logic  access_we;
   logic  access_done;
   logic  access_skip_read;
   adr_t  access_adr;
   len_t  access_len;
   line_t access_dat;
   line_t access_rdat;

   double_buffer u_double_buffer (
      .clk                (clk),
      .rst_n_i            (rst_n_i),
      .access_we_i        (access_we),
      .access_stb_i       (access_stb),
      .access_ok_o        (access_ok),
      .access_done_i      (access_done),
      .access_skip_read_i (access_skip_read),
      .access_adr_i       (access_adr),
      .access_len_o       (access_len),
      .access_dat_i       (access_dat),
      .access_dat_o       (access_rdat),
      .data_i             (in_data_i),
      .src_rdy_i          (in_src_rdy_i),
      .dst_rdy_o          (in_dst_rdy_o),
      .data_o             (out_data_o),
      .src_rdy_o          (out_src_rdy_o),
      .dst_rdy_i          (out_dst_rdy_i)
   );

   hdr_tagger u_hdr_tagger (
      .clk                (clk),
      .rst_n_i            (rst_n_i),
      .access_ok_i        (access_ok),
      .access_len_i       (access_len),
      .access_dat_i       (access_rdat),
      .access_stb_o       (access_stb),
      .access_we_o        (access_we),
      .access_adr_o       (access_adr),
      .access_dat_o       (access_dat),
      .access_done_o      (access_done),
      .access_skip_read_o (access_skip_read)
   );

endmodule

`default_nettype wire

//--- tb_pkt_tag_top.sv
// Directed testbench for pkt_tag_top with a packet model, compare tasks and a watchdog
`timescale 1ns/1ps
`default_nettype none

`include "pkt_tag_settings.svh"

module tb_pkt_tag_top
   import pkt_tag_pkg::*;
();

   localparam int CLK_PERIOD      = 40;
   localparam int DRIVE_DLY       = 2;
   localparam int RESET_CYCLES    = 16;
   localparam int NUM_TESTS       = 5;
   localparam int CYCLES_PER_TEST = 4000;
   localparam int WATCHDOG_NS     = (NUM_TESTS * CYCLES_PER_TEST + RESET_CYCLES) * CLK_PERIOD;
   localparam int BANK_LINES      = 1 << `PKT_TAG_AW;

   logic  clk = 1'b0;
   logic  rst_n_i;
   line_t in_data_i;
   logic  in_src_rdy_i;
   logic  in_dst_rdy_o;
   line_t out_data_o;
   logic  out_src_rdy_o;
   logic  out_dst_rdy_i;

   // Packet model state
   line_t tx_q [$];
   line_t exp_q [$];
   len_t  exp_len_q [$];
   seq_t  seq_model;
   logic  stall_en;
   logic  both_busy_seen;

   bank_state_t bank0_state;
   bank_state_t bank1_state;

   pkt_tag_top UUT (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .in_data_i     (in_data_i),
      .in_src_rdy_i  (in_src_rdy_i),
      .in_dst_rdy_o  (in_dst_rdy_o),
      .out_data_o    (out_data_o),
      .out_src_rdy_o (out_src_rdy_o),
      .out_dst_rdy_i (out_dst_rdy_i)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   assign bank0_state = UUT.u_double_buffer.u_dbsm.state_q[0];
   assign bank1_state = UUT.u_double_buffer.u_dbsm.state_q[1];

   // Notes when both banks hold a complete packet at the same time
   always @(negedge clk)
   begin
      if (((bank0_state == BANK_ACCESS) || (bank0_state == BANK_READING)) &&
          ((bank1_state == BANK_ACCESS) || (bank1_state == BANK_READING)))
      begin
         both_busy_seen = 1'b1;
      end
   end

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Test FAILED");
      $fatal(1);
   endtask

   task automatic check_line(input line_t got, input line_t exp, input string what);
      if (got !== exp)
      begin
         abort_run($sformatf("FAILED at time %0t: %s is %h, expected %h",
                             $time, what, got, exp));
      end
   endtask

   task automatic check_count(input len_t got, input len_t exp, input string what);
      if (got !== exp)
      begin
         abort_run($sformatf("FAILED at time %0t: %s is %0d lines, expected %0d",
                             $time, what, got, exp));
      end
   endtask

   // Queues one packet for sending and adds its expected form to the model
   task automatic build_packet(input int len, input logic drop);
      line_t l;
      for (int i = 0; i < len; i++)
      begin
         l           = '0;
         l[31:0]     = $urandom();
         l[35]       = 1'($urandom_range(1, 0));
         l[SOF_BIT]  = (i == 0);
         l[EOF_BIT]  = (i == len - 1);
         l[DROP_BIT] = drop && (i == 0);
         tx_q.push_back(l);
         if (!drop)
         begin
            if (i == 0)
            begin
               l[15:0]  = 16'(len);
               l[31:16] = seq_model;
            end
            exp_q.push_back(l);
         end
      end
      if (!drop)
      begin
         exp_len_q.push_back(len_t'(len));
         seq_model = seq_model + seq_t'(1);
      end
   endtask

   task automatic send_lines();
      line_t l;
      logic  accepted;
      while (tx_q.size() > 0)
      begin
         l = tx_q.pop_front();
         // Idle gaps on the source side
         while (stall_en && ($urandom_range(2, 0) == 0))
         begin
            in_src_rdy_i = 1'b0;
            @(posedge clk);
            #DRIVE_DLY;
         end
         in_data_i    = l;
         in_src_rdy_i = 1'b1;
         accepted     = 1'b0;
         while (!accepted)
         begin
            @(negedge clk);
            accepted = in_dst_rdy_o;
            @(posedge clk);
            #DRIVE_DLY;
         end
      end
      in_src_rdy_i = 1'b0;
   endtask

   task automatic receive_lines();
      line_t got;
      logic  take;
      int    count;
      int    pkt;
      count = 0;
      pkt   = 0;
      while (exp_q.size() > 0)
      begin
         out_dst_rdy_i = stall_en ? 1'($urandom_range(1, 0)) : 1'b1;
         @(negedge clk);
         take = out_src_rdy_o && out_dst_rdy_i;
         got  = out_data_o;
         @(posedge clk);
         #DRIVE_DLY;
         if (take)
         begin
            check_line(got, exp_q.pop_front(),
                       $sformatf("packet %0d line %0d", pkt, count));
            count++;
            if (got[EOF_BIT])
            begin
               check_count(len_t'(count), exp_len_q.pop_front(),
                           $sformatf("packet %0d length", pkt));
               count = 0;
               pkt++;
            end
         end
      end
      out_dst_rdy_i = 1'b0;
   endtask

   task automatic run_traffic();
      fork
         send_lines();
         receive_lines();
      join
   endtask

   task automatic expect_idle_output(input int cycles);
      repeat (cycles)
      begin
         @(negedge clk);
         if (out_src_rdy_o)
         begin
            abort_run("Output stream presented a line that no packet should produce");
         end
      end
      @(posedge clk);
      #DRIVE_DLY;
   endtask

   task automatic single_packet();
      $display("Single five-line packet");
      build_packet(5, 1'b0);
      run_traffic();
   endtask

   task automatic back_to_back();
      $display("Ten back-to-back packets");
      both_busy_seen = 1'b0;
      for (int i = 0; i < 10; i++)
      begin
         build_packet($urandom_range(40, 1), 1'b0);
      end
      run_traffic();
      if (!both_busy_seen)
      begin
         abort_run("The two banks were never busy at the same time");
      end
   endtask

   task automatic drop_packet();
      $display("Dropped packets");
      build_packet(6, 1'b0);
      build_packet(9, 1'b1);
      build_packet(4, 1'b0);
      build_packet(3, 1'b1);
      run_traffic();
      expect_idle_output(50);
   endtask

   task automatic random_stalls();
      $display("Random stalls on both streams");
      stall_en = 1'b1;
      for (int i = 0; i < 8; i++)
      begin
         build_packet($urandom_range(30, 1), (i == 3));
      end
      run_traffic();
      stall_en = 1'b0;
   endtask

   task automatic length_extremes();
      $display("One-line and full-bank packets");
      build_packet(1, 1'b0);
      build_packet(BANK_LINES, 1'b0);
      run_traffic();
   endtask

   initial
   begin
      void'($urandom(32'h69dfe35f));
      rst_n_i       = 1'b0;
      in_data_i     = '0;
      in_src_rdy_i  = 1'b0;
      out_dst_rdy_i = 1'b0;
      stall_en      = 1'b0;
      seq_model     = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DLY;
      rst_n_i = 1'b1;
      @(negedge clk);
      if (!in_dst_rdy_o || out_src_rdy_o)
      begin
         abort_run("Stream ready signals are wrong after reset");
      end
      @(posedge clk);
      #DRIVE_DLY;
      single_packet();
      back_to_back();
      drop_packet();
      random_stalls();
      length_extremes();
      $display("Test OK");
      $finish;
   end

   // Watchdog
   initial
   begin
      #(WATCHDOG_NS);
      abort_run($sformatf("Simulation timed out at %0t with banks %s and %s",
                          $time, bank0_state.name(), bank1_state.name()));
   end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
pkt_tag_pkg.sv
ram_2port.sv
dbsm.sv
double_buffer.sv
hdr_tagger.sv
pkt_tag_top.sv
tb_pkt_tag_top.sv

//--- Bender.yml
package:
  name: pkt_tag

export_include_dirs:
  - .

sources:
  - files:
      - pkt_tag_pkg.sv
      - ram_2port.sv
      - dbsm.sv
      - double_buffer.sv
      - hdr_tagger.sv
      - pkt_tag_top.sv
  - target: test
    files:
      - tb_pkt_tag_top.sv
